// File: src.f
+incdir+rtl
rtl/fabric_pkg.sv
rtl/lint_slave_fsm.sv
rtl/fabric_regfile.sv
rtl/tcdm_master_bank.sv
rtl/cycle_counter.sv
rtl/efpga_test_top.sv
sim/tb_efpga_test.sv

// File: sim/tb_efpga_test.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module tb_efpga_test
   import fabric_pkg::*;
();

   localparam int TMO = 40;

   logic CLK, arst_n, lint_req, lint_wen, lint_gnt, lint_valid;
   logic [`FAB_ADDR_W-1:0] lint_addr;
   logic [`FAB_DATA_W-1:0] lint_wdata, lint_rdata, oper0_rdata, oper1_rdata, coef_rdata;
   logic [3:0] lint_be;
   tcdm_req_t [`TCDM_PORTS-1:0] tcdm_req;
   logic [`TCDM_PORTS-1:0][`FAB_DATA_W-1:0] tcdm_rdata;
   logic [`TCDM_PORTS-1:0] tcdm_gnt, tcdm_valid;
   ram_wr_t oper0_wr, oper1_wr, coef_wr;
   logic [`RAM_ADDR_W-1:0] oper0_raddr, oper1_raddr, coef_raddr;
   ram_mode_t ram_mode;
   mac_ctrl_t [`MAC_UNITS-1:0] mac_ctrl;
   logic [`MAC_UNITS-1:0] mac_clken;
   logic [`MAC_UNITS-1:0][`FAB_DATA_W-1:0] mac_dout;

   logic [15:0] lfsr = 16'd50;
   int err_cnt = 0, to_cnt = 0, rd_issued = 0, rd_checked = 0;
   int clken_cnt [`MAC_UNITS] = '{default: 0};
   int we_cnt [4] = '{default: 0};
   logic [`RAM_ADDR_W-1:0] wr_addr [4], ra_q [4];
   logic [`FAB_DATA_W-1:0] wr_data [4], mac_sh [`MAC_UNITS], result_sh [`TCDM_PORTS];
   logic [`FAB_DATA_W-1:0] ram_ctrl_sh = '0, last_rd = '1, exp_rd, w, d, c1, c2, diff;
   logic [`FAB_ADDR_W-1:0] rd_addr, a;
   logic rd_pending = 1'b0;
   tcdm_req_t exp_port;

   efpga_test_top dut (.*);

   initial begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);   // one step per bit
      end
      return v;
   endfunction

   function automatic logic [31:0] ram_val(input int win, input logic [11:0] ra);
      return {4'ha, 4'(win), ra ^ 12'h3c5, ra};
   endfunction

   function automatic logic [31:0] tcdm_data(input int p, input logic [19:0] ta);
      return {4'(p), 8'h7e, ta};
   endfunction

   function automatic logic [31:0] dout_val(input int u);
      return {16'hd0d0, 16'(u)};
   endfunction

   // expected rdata from the shadow registers
   function automatic logic [31:0] ref_rdata(input logic [19:0] ra);
      logic [7:0] win;
      win = ra[19:12];
      if (win == `WIN_OPER0 || win == `WIN_OPER1 || win == `WIN_COEF) return ram_val(win, ra[11:0]);
      if (ra == `OFS_ID) return `FAB_ID;
      if (ra == `OFS_RAM_CTRL) return ram_ctrl_sh;
      for (int n = 0; n < `TCDM_PORTS; n++) begin
         if (ra == `OFS_TCDM_ADDR + 4 * n) return tcdm_rdata[n];   // live port data
         if (ra == `OFS_TCDM_WDATA + 4 * n) return result_sh[n];
      end
      for (int n = 0; n < `MAC_UNITS; n++) begin
         if (ra == `OFS_MAC_CTRL + 4 * n) return mac_sh[n];
         if (ra == `OFS_MAC_DOUT + 4 * n) return dout_val(n);
      end
      return last_rd;   // unmapped
   endfunction

   task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string what);
      assert (act === exp) else begin
         err_cnt++;
         $display("ERR %0t: %s got %h expected %h", $time, what, act, exp);
      end
   endtask

   task automatic check_quiet(input string when);
      logic [`TCDM_PORTS-1:0] reqs;
      for (int p = 0; p < `TCDM_PORTS; p++) reqs[p] = tcdm_req[p].req;
      assert ({lint_gnt, lint_valid, reqs, oper0_wr.we, oper1_wr.we, coef_wr.we, mac_clken} == '0)
      else begin
         err_cnt++;
         $display("ERR %0t: control outputs not idle %s", $time, when);
      end
   endtask

   task automatic finish_run();
      $display("errors: %0d mismatches, %0d timeouts", err_cnt, to_cnt);
      if (err_cnt == 0 && to_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   endtask

   task automatic abort_run(input string what);
      to_cnt++;
      $display("timeout at %0t: %s did not arrive", $time, what);
      finish_run();
   endtask

   // sampled 1 ns after the edge, returns 1 ns later
   task automatic wait_bus(input bit for_valid, output int n);
      n = 0;
      do begin
         @(posedge CLK);
         #1;
         n++;
         if (n > TMO) abort_run(for_valid ? "lint valid" : "lint gnt");
      end while (!(for_valid ? lint_valid : lint_gnt));
      #1;
   endtask

   task automatic bus_write(input logic [19:0] wa, input logic [31:0] wd, input logic [3:0] wb);
      int n;
      lint_addr  = wa;
      lint_wdata = wd;
      lint_be    = wb;
      lint_wen   = 1'b0;
      lint_req   = 1'b1;
      wait_bus(0, n);
      check_eq(n, 1, "write gnt delay");
      lint_req = 1'b0;
      wait_bus(1, n);
      check_eq(n, 1, "write valid delay");
      for (int u = 0; u < `MAC_UNITS; u++) begin
         if (wa == `OFS_MAC_CTRL + 4 * u) mac_sh[u] = wd;
      end
      if (wa == `OFS_RAM_CTRL) ram_ctrl_sh = wd;
   endtask

   task automatic bus_read(input logic [19:0] ra, input bit chk, output logic [31:0] rd);
      int n;
      exp_rd     = ref_rdata(ra);
      rd_addr    = ra;
      rd_pending = chk;
      rd_issued += chk;
      lint_addr  = ra;
      lint_wen   = 1'b1;
      lint_req   = 1'b1;
      wait_bus(0, n);
      check_eq(n, 3, "read gnt delay");
      lint_req = 1'b0;
      wait_bus(1, n);
      check_eq(n, 1, "read valid delay");
      rd         = lint_rdata;
      last_rd    = chk ? exp_rd : rd;
      rd_pending = 1'b0;
   endtask

   // TCDM slave with a random stall before gnt and valid
   task automatic respond(input int p, input tcdm_req_t exp);
      int n, hold;
      n = 0;
      do begin
         @(posedge CLK);
         #1;
         n++;
         if (n > TMO) abort_run("tcdm req");
      end while (!tcdm_req[p].req);
      check_eq(tcdm_req[p], exp, "tcdm launch fields");
      hold = rand_bits(2);
      #1;
      repeat (hold) begin
         @(posedge CLK);
         #1;
         check_eq(tcdm_req[p], exp, "tcdm fields under stall");
         #1;
      end
      tcdm_gnt[p] = 1'b1;
      @(posedge CLK);
      #1;
      check_eq(tcdm_req[p].req, 0, "tcdm req after gnt");
      #1;
      tcdm_gnt[p]   = 1'b0;
      tcdm_valid[p] = 1'b1;
      tcdm_rdata[p] = tcdm_data(p, exp.addr);
      result_sh[p]  = tcdm_rdata[p];
      @(posedge CLK);
      #2;
      tcdm_valid[p] = 1'b0;
   endtask

   // RAM model with one cycle from raddr to rdata
   always @(posedge CLK) begin
      #2;
      oper0_rdata = ram_val(`WIN_OPER0, ra_q[1]);
      oper1_rdata = ram_val(`WIN_OPER1, ra_q[2]);
      coef_rdata  = ram_val(`WIN_COEF, ra_q[3]);
      ra_q[1] = oper0_raddr;
      ra_q[2] = oper1_raddr;
      ra_q[3] = coef_raddr;
   end

   always @(posedge CLK) begin
      #1;
      for (int u = 0; u < `MAC_UNITS; u++) clken_cnt[u] += mac_clken[u];
      if (oper0_wr.we) begin
         we_cnt[1]++;
         wr_addr[1] = oper0_wr.waddr;
         wr_data[1] = oper0_wr.wdata;
      end
      if (oper1_wr.we) begin
         we_cnt[2]++;
         wr_addr[2] = oper1_wr.waddr;
         wr_data[2] = oper1_wr.wdata;
      end
      if (coef_wr.we) begin
         we_cnt[3]++;
         wr_addr[3] = coef_wr.waddr;
         wr_data[3] = coef_wr.wdata;
      end
   end

   always @(posedge CLK) begin
      #1;
      if (lint_valid && rd_pending) begin
         rd_checked++;
         assert (lint_rdata === exp_rd) else begin
            err_cnt++;
            $display("ERR %0t: rdata at %h got %h expected %h", $time, rd_addr, lint_rdata, exp_rd);
         end
      end
   end

   initial begin
      {lint_req, lint_addr, lint_wdata, lint_be} = '0;
      lint_wen   = 1'b1;
      tcdm_rdata = '0;
      tcdm_gnt   = '0;
      tcdm_valid = '0;
      ra_q       = '{default: '0};
      {oper0_rdata, oper1_rdata, coef_rdata} = '0;
      for (int u = 0; u < `MAC_UNITS; u++) mac_dout[u] = dout_val(u);
      arst_n = 1'b0;
      repeat (5) @(posedge CLK);
      #1;
      check_quiet("during reset");
      check_eq(lint_rdata, 32'hffffffff, "rdata in reset");
      repeat (5) @(posedge CLK);
      #2 arst_n = 1'b1;
      @(posedge CLK);
      #1;
      check_quiet("after reset");
      #1;

      bus_read(`OFS_ID, 1, d);
      bus_read('h7fc, 1, d);

      for (int u = 0; u < `MAC_UNITS; u++) begin
         w = rand_bits(32);
         bus_write(`OFS_MAC_CTRL + 4 * u, w, 4'hf);
         bus_read(`OFS_MAC_CTRL + 4 * u, 1, d);
         check_eq(mac_ctrl[u].outsel, w[5:0], "mac outsel");
         check_eq(mac_ctrl[u].tc, w[6], "mac tc");
         check_eq(mac_ctrl[u].mode, w[13:12], "mac mode");
         check_eq({mac_ctrl[u].rnd, mac_ctrl[u].csel, mac_ctrl[u].osel}, w[16:14], "mac sel/rnd");
         check_eq({mac_ctrl[u].clr, mac_ctrl[u].sat}, {w[17], w[18]}, "mac clr/sat");
         check_eq(mac_ctrl[u].reset, w[31], "mac reset");
      end
      w = rand_bits(32);
      bus_write(`OFS_RAM_CTRL, w, 4'hf);
      bus_read(`OFS_RAM_CTRL, 1, d);
      check_eq({ram_mode.oper0_wmode, ram_mode.oper0_rmode}, w[3:0], "oper0 mode");
      check_eq({ram_mode.oper1_wmode, ram_mode.oper1_rmode}, w[7:4], "oper1 mode");
      check_eq({ram_mode.coef_wmode, ram_mode.coef_rmode}, w[11:8], "coef mode");
      check_eq({ram_mode.coef_wdsel, ram_mode.oper1_wdsel, ram_mode.oper0_wdsel}, w[14:12], "wdsel");

      for (int u = 0; u < `MAC_UNITS; u++) begin
         bus_write(`OFS_CLKEN + 4 * u, '0, 4'hf);
         repeat (2) @(posedge CLK);
         #2;
         check_eq(clken_cnt[0], 1, "clken pulses unit 0");
         check_eq(clken_cnt[1], u, "clken pulses unit 1");
      end

      for (int wc = 1; wc <= 3; wc++) begin
         a = {8'(wc), 12'(rand_bits(12))};
         w = rand_bits(32);
         bus_write(a, w, 4'hf);
         repeat (2) @(posedge CLK);
         #2;
         for (int k = 1; k <= 3; k++) begin
            check_eq(we_cnt[k], k <= wc, "ram we pulses");
         end
         check_eq({wr_addr[wc], wr_data[wc]}, {a[11:0], w}, "ram write port");
         bus_read(a, 1, d);
         check_eq(wc == 1 ? oper0_raddr : wc == 2 ? oper1_raddr : coef_raddr, a[11:0], "raddr");
      end

      for (int p = 0; p < `TCDM_PORTS; p++) begin
         exp_port = '{addr: rand_bits(20), wdata: rand_bits(32), be: rand_bits(4),
                      wen: rand_bits(1), req: 1'b1};
         bus_write(`OFS_TCDM_ADDR + 4 * p, {exp_port.wen, 11'b0, exp_port.addr}, exp_port.be);
         bus_write(`OFS_TCDM_WDATA + 4 * p, exp_port.wdata, 4'hf);
         fork
            bus_write(`OFS_TCDM_REQ + 4 * p, '0, 4'hf);
            respond(p, exp_port);
         join
         bus_read(`OFS_TCDM_WDATA + 4 * p, 1, d);
         bus_read(`OFS_TCDM_ADDR + 4 * p, 1, d);
      end

      bus_read(`OFS_STATUS, 0, c1);
      repeat (4) bus_read(`OFS_ID, 1, d);
      bus_read(`OFS_STATUS, 0, c2);
      diff = (c2 - c1) & ((32'd1 << `CNT_W) - 1);   // wrap-safe
      assert (diff >= 1 && diff <= 6 * TMO) else begin
         err_cnt++;
         $display("ERR %0t: counter moved by %0d between status reads", $time, diff);
      end
      check_eq(rd_checked, rd_issued, "checked reads");
      finish_run();
   end

endmodule

// File: rtl/efpga_test_top.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module efpga_test_top
   import fabric_pkg::*;
(
   input  logic                                     CLK,
   input  logic                                     arst_n,
   input  logic                                     lint_req,
   input  logic                                     lint_wen,      // 0 is write
   input  logic [`FAB_ADDR_W-1:0]                   lint_addr,
   input  logic [`FAB_DATA_W-1:0]                   lint_wdata,
   input  logic [3:0]                               lint_be,
   output logic                                     lint_gnt,
   output logic                                     lint_valid,
   output logic [`FAB_DATA_W-1:0]                   lint_rdata,
   output tcdm_req_t [`TCDM_PORTS-1:0]              tcdm_req,
   input  logic [`TCDM_PORTS-1:0][`FAB_DATA_W-1:0]  tcdm_rdata,
   input  logic [`TCDM_PORTS-1:0]                   tcdm_gnt,
   input  logic [`TCDM_PORTS-1:0]                   tcdm_valid,
   output ram_wr_t                                  oper0_wr,
   output ram_wr_t                                  oper1_wr,
   output ram_wr_t                                  coef_wr,
   output logic [`RAM_ADDR_W-1:0]                   oper0_raddr,
   output logic [`RAM_ADDR_W-1:0]                   oper1_raddr,
   output logic [`RAM_ADDR_W-1:0]                   coef_raddr,
   input  logic [`FAB_DATA_W-1:0]                   oper0_rdata,
   input  logic [`FAB_DATA_W-1:0]                   oper1_rdata,
   input  logic [`FAB_DATA_W-1:0]                   coef_rdata,
   output ram_mode_t                                ram_mode,
   output mac_ctrl_t [`MAC_UNITS-1:0]               mac_ctrl,
   output logic [`MAC_UNITS-1:0]                    mac_clken,
   input  logic [`MAC_UNITS-1:0][`FAB_DATA_W-1:0]   mac_dout
);

   bus_req_t                               bus;
   tcdm_cfg_t                              tcdm_cfg;
   logic [`TCDM_PORTS-1:0][`FAB_DATA_W-1:0] tcdm_result;
   cnt_t                                   count;
   logic                                   rd_accept, wr_stb, rd_stb, ram_stb;

   assign bus = '{addr: lint_addr, wdata: lint_wdata, be: lint_be, wr: ~lint_wen};

   lint_slave_fsm u_fsm (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .req       (lint_req),
      .wen       (lint_wen),
      .gnt       (lint_gnt),
      .valid     (lint_valid),
      .rd_accept (rd_accept),
      .wr_stb    (wr_stb),
      .rd_stb    (rd_stb),
      .ram_stb   (ram_stb)
   );

   fabric_regfile u_regs (
      .CLK         (CLK),
      .arst_n      (arst_n),
      .bus         (bus),
      .rd_accept   (rd_accept),
      .wr_stb      (wr_stb),
      .rd_stb      (rd_stb),
      .ram_stb     (ram_stb),
      .tcdm_rdata  (tcdm_rdata),
      .tcdm_result (tcdm_result),
      .mac_dout    (mac_dout),
      .oper0_rdata (oper0_rdata),
      .oper1_rdata (oper1_rdata),
      .coef_rdata  (coef_rdata),
      .count       (count),
      .rdata       (lint_rdata),
      .tcdm_cfg    (tcdm_cfg),
      .mac_ctrl    (mac_ctrl),
      .mac_clken   (mac_clken),
      .ram_mode    (ram_mode),
      .oper0_wr    (oper0_wr),
      .oper1_wr    (oper1_wr),
      .coef_wr     (coef_wr),
      .oper0_raddr (oper0_raddr),
      .oper1_raddr (oper1_raddr),
      .coef_raddr  (coef_raddr)
   );

   tcdm_master_bank u_tcdm (
      .CLK    (CLK),
      .arst_n (arst_n),
      .cfg    (tcdm_cfg),
      .gnt    (tcdm_gnt),
      .valid  (tcdm_valid),
      .rdata  (tcdm_rdata),
      .port   (tcdm_req),
      .result (tcdm_result)
   );

   cycle_counter u_cnt (
      .CLK    (CLK),
      .arst_n (arst_n),
      .count  (count)
   );

endmodule

// File: rtl/cycle_counter.sv
`timescale 1ns/1ps

module cycle_counter
   import fabric_pkg::*;
(
   input  logic CLK,
   input  logic arst_n,
   output cnt_t count
);

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else begin
         count <= count + 1'b1;   // wraps
      end
   end

endmodule

// File: rtl/tcdm_master_bank.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module tcdm_master_bank
   import fabric_pkg::*;
(
   input  logic                                     CLK,
   input  logic                                     arst_n,
   input  tcdm_cfg_t                                cfg,
   input  logic [`TCDM_PORTS-1:0]                   gnt,
   input  logic [`TCDM_PORTS-1:0]                   valid,
   input  logic [`TCDM_PORTS-1:0][`FAB_DATA_W-1:0]  rdata,
   output tcdm_req_t [`TCDM_PORTS-1:0]              port,
   output logic [`TCDM_PORTS-1:0][`FAB_DATA_W-1:0]  result
);

   for (genvar p = 0; p < `TCDM_PORTS; p++) begin : g_port
      tcdm_req_t              port_q;
      logic [`FAB_DATA_W-1:0] result_q;

      always_ff @(posedge CLK or negedge arst_n) begin
         if (!arst_n) begin
            port_q   <= '0;
            result_q <= '0;
         end else begin
            if (cfg.sel_addr[p]) begin
               port_q.addr <= cfg.data[`FAB_ADDR_W-1:0];
               port_q.wen  <= cfg.data[`FAB_DATA_W-1];
               port_q.be   <= cfg.be;
            end
            if (cfg.sel_wdata[p]) port_q.wdata <= cfg.data;

            // a new launch beats a grant in the same cycle
            if (cfg.sel_req[p]) begin
               port_q.req <= 1'b1;
            end else if (gnt[p]) begin
               port_q.req <= 1'b0;
            end

            if (valid[p]) result_q <= rdata[p];
         end
      end

      assign port[p]   = port_q;
      assign result[p] = result_q;
   end

endmodule

// File: rtl/fabric_regfile.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module fabric_regfile
   import fabric_pkg::*;
(
   input  logic                                     CLK,
   input  logic                                     arst_n,
   input  bus_req_t                                 bus,
   input  logic                                     rd_accept,
   input  logic                                     wr_stb,
   input  logic                                     rd_stb,
   input  logic                                     ram_stb,
   input  logic [`TCDM_PORTS-1:0][`FAB_DATA_W-1:0]  tcdm_rdata,
   input  logic [`TCDM_PORTS-1:0][`FAB_DATA_W-1:0]  tcdm_result,
   input  logic [`MAC_UNITS-1:0][`FAB_DATA_W-1:0]   mac_dout,
   input  logic [`FAB_DATA_W-1:0]                   oper0_rdata,
   input  logic [`FAB_DATA_W-1:0]                   oper1_rdata,
   input  logic [`FAB_DATA_W-1:0]                   coef_rdata,
   input  cnt_t                                     count,
   output logic [`FAB_DATA_W-1:0]                   rdata,
   output tcdm_cfg_t                                tcdm_cfg,
   output mac_ctrl_t [`MAC_UNITS-1:0]               mac_ctrl,
   output logic [`MAC_UNITS-1:0]                    mac_clken,
   output ram_mode_t                                ram_mode,
   output ram_wr_t                                  oper0_wr,
   output ram_wr_t                                  oper1_wr,
   output ram_wr_t                                  coef_wr,
   output logic [`RAM_ADDR_W-1:0]                   oper0_raddr,
   output logic [`RAM_ADDR_W-1:0]                   oper1_raddr,
   output logic [`RAM_ADDR_W-1:0]                   coef_raddr
);

   localparam int NWIN = 3;
   localparam logic [7:0] WIN_CODE [NWIN] = '{`WIN_OPER0, `WIN_OPER1, `WIN_COEF};

   logic [`TCDM_PORTS-1:0] hit_taddr, hit_twdata, hit_treq;
   logic [`MAC_UNITS-1:0]  hit_mac, hit_clken, hit_dout;
   logic [NWIN-1:0]        hit_win;
   logic                   hit_ram_ctrl, hit_status, hit_id;

   logic [`FAB_DATA_W-1:0] ram_ctrl_q;
   logic [`FAB_DATA_W-1:0] rd_val;
   logic                   rd_hit;
   logic [`FAB_DATA_W-1:0] ram_rdata [NWIN];
   ram_wr_t                ram_wr [NWIN];
   logic [`RAM_ADDR_W-1:0] raddr [NWIN];

   always_comb begin
      hit_taddr    = '0;
      hit_twdata   = '0;
      hit_treq     = '0;
      hit_mac      = '0;
      hit_clken    = '0;
      hit_dout     = '0;
      hit_win      = '0;
      hit_ram_ctrl = (bus.addr == `OFS_RAM_CTRL);
      hit_status   = (bus.addr == `OFS_STATUS);
      hit_id       = (bus.addr == `OFS_ID);
      for (int n = 0; n < `TCDM_PORTS; n++) begin
         hit_taddr[n]  = (bus.addr == `OFS_TCDM_ADDR + 4 * n);
         hit_twdata[n] = (bus.addr == `OFS_TCDM_WDATA + 4 * n);
         hit_treq[n]   = (bus.addr == `OFS_TCDM_REQ + 4 * n);
      end
      for (int n = 0; n < `MAC_UNITS; n++) begin
         hit_mac[n]   = (bus.addr == `OFS_MAC_CTRL + 4 * n);
         hit_clken[n] = (bus.addr == `OFS_CLKEN + 4 * n);
         hit_dout[n]  = (bus.addr == `OFS_MAC_DOUT + 4 * n);
      end
      for (int w = 0; w < NWIN; w++) begin
         hit_win[w] = (bus.addr[`FAB_ADDR_W-1:`RAM_ADDR_W] == WIN_CODE[w]);
      end
   end

   // register read value, windows excluded
   always_comb begin
      rd_hit = 1'b1;
      rd_val = '0;
      if (hit_id) begin
         rd_val = `FAB_ID;
      end else if (hit_status) begin
         rd_val = {{(`FAB_DATA_W - `CNT_W){1'b0}}, count};
      end else if (hit_ram_ctrl) begin
         rd_val = ram_ctrl_q;
      end else begin
         rd_hit = 1'b0;
         for (int n = 0; n < `TCDM_PORTS; n++) begin
            if (hit_taddr[n] || hit_twdata[n]) begin
               rd_hit = 1'b1;
               rd_val = hit_taddr[n] ? tcdm_rdata[n] : tcdm_result[n];
            end
         end
         for (int n = 0; n < `MAC_UNITS; n++) begin
            if (hit_mac[n] || hit_dout[n]) begin
               rd_hit = 1'b1;
               rd_val = hit_mac[n] ? mac_ctrl[n] : mac_dout[n];
            end
         end
      end
   end

   assign ram_rdata = '{oper0_rdata, oper1_rdata, coef_rdata};

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         mac_ctrl   <= '0;
         mac_clken  <= '0;
         ram_ctrl_q <= '0;
         rdata      <= '1;
         for (int w = 0; w < NWIN; w++) begin
            ram_wr[w] <= '0;
            raddr[w]  <= '0;
         end
      end else begin
         mac_clken <= '0;   // one-cycle pulses
         for (int w = 0; w < NWIN; w++) begin
            ram_wr[w].we <= 1'b0;
         end
         if (wr_stb) begin
            for (int n = 0; n < `MAC_UNITS; n++) begin
               if (hit_mac[n]) mac_ctrl[n] <= mac_ctrl_t'(bus.wdata);
               if (hit_clken[n]) mac_clken[n] <= 1'b1;
            end
            if (hit_ram_ctrl) ram_ctrl_q <= bus.wdata;
            for (int w = 0; w < NWIN; w++) begin
               if (hit_win[w]) begin
                  ram_wr[w] <= '{waddr: bus.addr[`RAM_ADDR_W-1:0], wdata: bus.wdata, we: 1'b1};
               end
            end
         end
         if (rd_accept) begin
            for (int w = 0; w < NWIN; w++) begin
               if (hit_win[w]) raddr[w] <= bus.addr[`RAM_ADDR_W-1:0];
            end
         end
         if (rd_stb && rd_hit) rdata <= rd_val;   // unmapped keeps old value
         if (ram_stb) begin
            for (int w = 0; w < NWIN; w++) begin
               if (hit_win[w]) rdata <= ram_rdata[w];
            end
         end
      end
   end

   assign tcdm_cfg = '{sel_addr:  hit_taddr & {`TCDM_PORTS{wr_stb}},
                       sel_wdata: hit_twdata & {`TCDM_PORTS{wr_stb}},
                       sel_req:   hit_treq & {`TCDM_PORTS{wr_stb}},
                       data:      bus.wdata,
                       be:        bus.be};

   assign ram_mode    = ram_mode_t'(ram_ctrl_q[$bits(ram_mode_t)-1:0]);
   assign oper0_wr    = ram_wr[0];
   assign oper1_wr    = ram_wr[1];
   assign coef_wr     = ram_wr[2];
   assign oper0_raddr = raddr[0];
   assign oper1_raddr = raddr[1];
   assign coef_raddr  = raddr[2];

endmodule

// File: rtl/lint_slave_fsm.sv
`timescale 1ns/1ps

module lint_slave_fsm
   import fabric_pkg::*;
(
   input  logic CLK,
   input  logic arst_n,
   input  logic req,
   input  logic wen,
   output logic gnt,
   output logic valid,
   output logic rd_accept,
   output logic wr_stb,
   output logic rd_stb,
   output logic ram_stb
);

   lint_state_e state;
   logic        accept;

   // gnt still high means the last request is not yet released
   assign accept    = (state == ST_IDLE) && req && !gnt;
   assign rd_accept = accept && wen;

   assign wr_stb  = (state == ST_WRITE);
   assign rd_stb  = (state == ST_READ);
   assign ram_stb = (state == ST_READ_WAIT);

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_IDLE;
         gnt   <= 1'b0;
         valid <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               valid <= gnt;   // closes a read
               gnt   <= 1'b0;
               if (accept) begin
                  if (!wen) begin
                     gnt   <= 1'b1;
                     state <= ST_WRITE;
                  end else begin
                     state <= ST_READ;
                  end
               end
            end
            ST_WRITE: begin
               valid <= gnt;
               gnt   <= 1'b0;
               state <= ST_IDLE;
            end
            ST_READ: begin
               valid <= 1'b0;
               state <= ST_READ_WAIT;   // give the RAM its cycle
            end
            ST_READ_WAIT: begin
               gnt   <= 1'b1;           // rdata is final here
               state <= ST_IDLE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

// File: rtl/fabric_pkg.sv
`include "fabric_settings.svh"

package fabric_pkg;

   typedef logic [`CNT_W-1:0] cnt_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WRITE,
      ST_READ,
      ST_READ_WAIT
   } lint_state_e;

   typedef struct packed {
      logic [`FAB_ADDR_W-1:0] addr;
      logic [`FAB_DATA_W-1:0] wdata;
      logic [3:0]             be;
      logic                   wr;    // 1 for a write
   } bus_req_t;

   typedef struct packed {
      logic       reset;
      logic [11:0] rsvd_hi;   // kept for readback
      logic       sat;
      logic       clr;
      logic       rnd;
      logic       csel;
      logic       osel;
      logic [1:0] mode;
      logic [4:0] rsvd_lo;
      logic       tc;
      logic [5:0] outsel;
   } mac_ctrl_t;

   typedef struct packed {
      logic       coef_wdsel;
      logic       oper1_wdsel;
      logic       oper0_wdsel;
      logic [1:0] coef_wmode;
      logic [1:0] coef_rmode;
      logic [1:0] oper1_wmode;
      logic [1:0] oper1_rmode;
      logic [1:0] oper0_wmode;
      logic [1:0] oper0_rmode;
   } ram_mode_t;

   typedef struct packed {
      logic [`RAM_ADDR_W-1:0] waddr;
      logic [`FAB_DATA_W-1:0] wdata;
      logic                   we;
   } ram_wr_t;

   typedef struct packed {
      logic [`FAB_ADDR_W-1:0] addr;
      logic [`FAB_DATA_W-1:0] wdata;
      logic [3:0]             be;
      logic                   wen;
      logic                   req;
   } tcdm_req_t;

   typedef struct packed {
      logic [`TCDM_PORTS-1:0] sel_addr;
      logic [`TCDM_PORTS-1:0] sel_wdata;
      logic [`TCDM_PORTS-1:0] sel_req;
      logic [`FAB_DATA_W-1:0] data;
      logic [3:0]             be;
   } tcdm_cfg_t;

endpackage

// File: rtl/fabric_settings.svh
`ifndef FABRIC_SETTINGS_SVH
`define FABRIC_SETTINGS_SVH

`define FAB_ADDR_W 20
`define FAB_DATA_W 32
`define RAM_ADDR_W 12
`define TCDM_PORTS 4
`define MAC_UNITS 2
`define CNT_W 15

`define FAB_ID 32'hca11ef3a

// port n and unit n sit at base + 4n
`define OFS_TCDM_ADDR 'h000
`define OFS_MAC_CTRL 'h010
`define OFS_RAM_CTRL 'h020
`define OFS_CLKEN 'h030
`define OFS_STATUS 'h068
`define OFS_TCDM_WDATA 'h080
`define OFS_TCDM_REQ 'h090
`define OFS_MAC_DOUT 'h100
`define OFS_ID 'h800

// window code lives in addr[19:12]
`define WIN_OPER0 8'h01
`define WIN_OPER1 8'h02
`define WIN_COEF 8'h03

`endif
